/* design/lsu_pkg.sv */
package lsu_pkg;

	// Instruction tag carried through the stage
	localparam int TAG_WIDTH = 4;

	typedef logic [TAG_WIDTH-1:0] tag_t;

	// Bus and register word
	localparam int DATA_WIDTH = 32;

	typedef logic [DATA_WIDTH-1:0] data_t;

	// Access width, coded as the number of bytes
	typedef logic [2:0] mem_width_t;

	localparam mem_width_t WIDTH_BYTE = 3'd1;
	localparam mem_width_t WIDTH_HALF = 3'd2;
	localparam mem_width_t WIDTH_WORD = 3'd4;

endpackage

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic                i_clock,
	input  logic                i_reset,

	// Pipeline side
	input  lsu_pkg::tag_t       i_tag,
	input  logic [4:0]          i_inst_rd,
	input  lsu_pkg::data_t      i_rd,
	input  lsu_pkg::data_t      i_pc_next,
	input  logic                i_mem_read,
	input  logic                i_mem_write,
	input  lsu_pkg::mem_width_t i_mem_width,
	input  logic                i_mem_signed,
	input  lsu_pkg::data_t      i_mem_address,

	// Bus side
	input  logic                i_bus_ready,
	input  lsu_pkg::data_t      i_bus_rdata,
	output logic                o_bus_request,
	output logic                o_bus_rw,
	output lsu_pkg::data_t      o_bus_address,
	output lsu_pkg::data_t      o_bus_wdata,

	// Retired instruction
	output lsu_pkg::tag_t       o_tag,
	output logic [4:0]          o_inst_rd,
	output lsu_pkg::data_t      o_rd,
	output lsu_pkg::data_t      o_pc_next,
	output logic                o_stall
);

	typedef enum logic [1:0] {
		STATE_IDLE,
		STATE_RMW_READ,
		STATE_RMW_REREQUEST,
		STATE_RMW_WRITE
	} state_t;

	state_t state;

	logic new_inst;
	logic in_idle;
	logic is_load;
	logic is_store;
	logic is_word;
	logic pass_through;
	logic single_access;
	logic start_rmw;
	logic load_done;
	logic retire;

	logic [1:0]     byte_index;
	lsu_pkg::data_t rdata_shifted;
	lsu_pkg::data_t load_value;
	logic [3:0]     lane_mask;
	lsu_pkg::data_t store_lanes;
	lsu_pkg::data_t merged_word;

	assign new_inst = (i_tag != o_tag);
	assign in_idle  = (state == STATE_IDLE);
	assign is_load  = i_mem_read;
	assign is_store = i_mem_write && !i_mem_read;
	assign is_word  = (i_mem_width == lsu_pkg::WIDTH_WORD);

	assign pass_through  = new_inst && in_idle && !i_mem_read && !i_mem_write;
	assign single_access = new_inst && in_idle && (is_load || (is_store && is_word));
	assign start_rmw     = new_inst && in_idle && is_store && !is_word;
	assign load_done     = single_access && is_load && i_bus_ready;

	assign retire = pass_through
		|| (single_access && i_bus_ready)
		|| ((state == STATE_RMW_WRITE) && i_bus_ready);

	// Hold the pipeline only for memory accesses
	assign o_stall = new_inst && (i_mem_read || i_mem_write);

	assign o_bus_address = {i_mem_address[31:2], 2'b00};

	assign byte_index    = i_mem_address[1:0];
	assign rdata_shifted = i_bus_rdata >> {byte_index, 3'b000};

	// Load extension
	always_comb begin
		case (i_mem_width)
			lsu_pkg::WIDTH_BYTE:
				load_value = {{24{i_mem_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
			lsu_pkg::WIDTH_HALF:
				load_value = {{16{i_mem_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
			default:
				load_value = i_bus_rdata;
		endcase
	end

	// Byte lanes written by a sub-word store
	always_comb begin
		if (i_mem_width == lsu_pkg::WIDTH_BYTE) begin
			lane_mask   = 4'b0001 << byte_index;
			store_lanes = {4{i_rd[7:0]}};
		end else begin
			lane_mask   = 4'b0011 << byte_index;
			store_lanes = {2{i_rd[15:0]}};
		end
	end

	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			if (lane_mask[lane]) begin
				merged_word[8*lane +: 8] = store_lanes[8*lane +: 8];
			end else begin
				merged_word[8*lane +: 8] = i_bus_rdata[8*lane +: 8];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= STATE_IDLE;
			o_bus_request <= 1'b0;
			o_bus_rw      <= 1'b0;
			o_tag         <= '0;
		end else begin
			case (state)
				STATE_IDLE: begin
					if (single_access) begin
						// Request drops on the edge that sees ready
						o_bus_request <= !i_bus_ready;
						o_bus_rw      <= is_store && !i_bus_ready;
					end else if (start_rmw) begin
						o_bus_request <= 1'b1;
						o_bus_rw      <= 1'b0;
						state         <= STATE_RMW_READ;
					end
				end

				STATE_RMW_READ: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw      <= 1'b1;
						state         <= STATE_RMW_REREQUEST;
					end
				end

				// One idle bus cycle before the write
				STATE_RMW_REREQUEST: begin
					o_bus_request <= 1'b1;
					state         <= STATE_RMW_WRITE;
				end

				STATE_RMW_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw      <= 1'b0;
						state         <= STATE_IDLE;
					end
				end

				default: begin
					state <= STATE_IDLE;
				end
			endcase

			if (retire) begin
				o_tag <= i_tag;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (retire) begin
			o_inst_rd <= i_inst_rd;
			o_pc_next <= i_pc_next;
		end

		if (load_done) begin
			o_rd <= load_value;
		end else if (pass_through) begin
			o_rd <= i_rd;
		end

		if ((state == STATE_RMW_READ) && i_bus_ready) begin
			o_bus_wdata <= merged_word;
		end else if (single_access && is_store) begin
			o_bus_wdata <= i_rd;
		end
	end

endmodule

/* design/bank_router.sv */
`timescale 1ns/1ps

module bank_router #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic                          i_clock,
	input  logic                          i_reset,

	input  logic                          i_bus_request,
	input  logic                          i_bus_rw,
	input  lsu_pkg::data_t                i_bus_address,
	input  lsu_pkg::data_t                i_bus_wdata,

	output logic [NUM_BANKS-1:0]          o_bank_request,
	output logic                          o_bank_rw,
	output logic [$clog2(BANK_WORDS)-1:0] o_bank_word_address,
	output lsu_pkg::data_t                o_bank_wdata
);

	localparam int BANK_BITS = $clog2(NUM_BANKS);
	localparam int ROW_BITS  = $clog2(BANK_WORDS);

	logic [BANK_BITS-1:0] bank_index;
	logic [ROW_BITS-1:0]  row;
	logic [NUM_BANKS-1:0] bank_select;

	// Word interleaving, upper address bits wrap
	assign bank_index  = i_bus_address[2 +: BANK_BITS];
	assign row         = i_bus_address[2 + BANK_BITS +: ROW_BITS];
	assign bank_select = {{(NUM_BANKS-1){1'b0}}, 1'b1} << bank_index;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bank_request <= '0;
			o_bank_rw      <= 1'b0;
		end else if (i_bus_request) begin
			o_bank_request <= bank_select;
			o_bank_rw      <= i_bus_rw;
		end else begin
			o_bank_request <= '0;
			o_bank_rw      <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_bus_request) begin
			o_bank_word_address <= row;
			o_bank_wdata        <= i_bus_wdata;
		end else begin
			o_bank_word_address <= '0;
			o_bank_wdata        <= '0;
		end
	end

endmodule

/* design/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank #(
	parameter int BANK_WORDS = 64
) (
	input  logic                          i_clock,
	input  logic                          i_reset,

	input  logic                          i_request,
	input  logic                          i_rw,
	input  logic [$clog2(BANK_WORDS)-1:0] i_word_address,
	input  lsu_pkg::data_t                i_wdata,

	output logic                          o_ready,
	output lsu_pkg::data_t                o_rdata
);

	lsu_pkg::data_t storage [BANK_WORDS];

	logic served;
	logic serve;

	// Only the first cycle of a request is served
	assign serve = i_request && !served;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			served  <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			// Clears after the request has been low for a cycle
			served  <= i_request;
			o_ready <= serve;
		end
	end

	always_ff @(posedge i_clock) begin
		if (serve) begin
			if (i_rw) begin
				storage[i_word_address] <= i_wdata;
			end else begin
				o_rdata <= storage[i_word_address];
			end
		end
	end

endmodule

/* design/bank_return.sv */
`timescale 1ns/1ps

module bank_return #(
	parameter int NUM_BANKS = 4
) (
	input  logic                 i_clock,
	input  logic                 i_reset,

	input  logic [NUM_BANKS-1:0] i_bank_ready,
	input  lsu_pkg::data_t       i_bank_rdata [NUM_BANKS],

	output logic                 o_bus_ready,
	output lsu_pkg::data_t       o_bus_rdata
);

	logic           any_ready;
	lsu_pkg::data_t selected_rdata;

	assign any_ready = |i_bank_ready;

	// At most one bank answers in a cycle
	always_comb begin
		selected_rdata = '0;
		for (int k = 0; k < NUM_BANKS; k++) begin
			if (i_bank_ready[k]) begin
				selected_rdata = i_bank_rdata[k];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= any_ready;
		end
	end

	always_ff @(posedge i_clock) begin
		if (any_ready) begin
			o_bus_rdata <= selected_rdata;
		end
	end

endmodule

/* design/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic                i_clock,
	input  logic                i_reset,

	input  lsu_pkg::tag_t       i_tag,
	input  logic [4:0]          i_inst_rd,
	input  lsu_pkg::data_t      i_rd,
	input  lsu_pkg::data_t      i_pc_next,
	input  logic                i_mem_read,
	input  logic                i_mem_write,
	input  lsu_pkg::mem_width_t i_mem_width,
	input  logic                i_mem_signed,
	input  lsu_pkg::data_t      i_mem_address,

	output lsu_pkg::tag_t       o_tag,
	output logic [4:0]          o_inst_rd,
	output lsu_pkg::data_t      o_rd,
	output lsu_pkg::data_t      o_pc_next,
	output logic                o_stall
);

	localparam int ROW_BITS = $clog2(BANK_WORDS);

	// Stage to router
	logic           bus_request;
	logic           bus_rw;
	lsu_pkg::data_t bus_address;
	lsu_pkg::data_t bus_wdata;

	// Collector to stage
	logic           bus_ready;
	lsu_pkg::data_t bus_rdata;

	logic [NUM_BANKS-1:0] bank_request;
	logic                 bank_rw;
	logic [ROW_BITS-1:0]  bank_word_address;
	lsu_pkg::data_t       bank_wdata;
	logic [NUM_BANKS-1:0] bank_ready;
	lsu_pkg::data_t       bank_rdata [NUM_BANKS];

	mem_stage mem_stage_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_tag         (i_tag),
		.i_inst_rd     (i_inst_rd),
		.i_rd          (i_rd),
		.i_pc_next     (i_pc_next),
		.i_mem_read    (i_mem_read),
		.i_mem_write   (i_mem_write),
		.i_mem_width   (i_mem_width),
		.i_mem_signed  (i_mem_signed),
		.i_mem_address (i_mem_address),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_pc_next     (o_pc_next),
		.o_stall       (o_stall)
	);

	bank_router #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_WORDS (BANK_WORDS)
	) bank_router_inst (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_bus_request       (bus_request),
		.i_bus_rw            (bus_rw),
		.i_bus_address       (bus_address),
		.i_bus_wdata         (bus_wdata),
		.o_bank_request      (bank_request),
		.o_bank_rw           (bank_rw),
		.o_bank_word_address (bank_word_address),
		.o_bank_wdata        (bank_wdata)
	);

	for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
		sram_bank #(
			.BANK_WORDS (BANK_WORDS)
		) sram_bank_inst (
			.i_clock        (i_clock),
			.i_reset        (i_reset),
			.i_request      (bank_request[k]),
			.i_rw           (bank_rw),
			.i_word_address (bank_word_address),
			.i_wdata        (bank_wdata),
			.o_ready        (bank_ready[k]),
			.o_rdata        (bank_rdata[k])
		);
	end

	bank_return #(
		.NUM_BANKS (NUM_BANKS)
	) bank_return_inst (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_bank_ready (bank_ready),
		.i_bank_rdata (bank_rdata),
		.o_bus_ready  (bus_ready),
		.o_bus_rdata  (bus_rdata)
	);

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic o_clock,
	output logic o_reset
);

	// 40 ns period
	initial begin
		o_clock = 1'b0;
		forever #20 o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

/* dv/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;

	localparam int NUM_BANKS    = 4;
	localparam int BANK_WORDS   = 64;
	localparam int MEM_WORDS    = NUM_BANKS * BANK_WORDS;
	localparam int RANDOM_COUNT = 300;
	localparam int INSTRUCTION_COUNT = 2 + MEM_WORDS + 32 + 26 + 12 + RANDOM_COUNT;

	logic clock;
	logic reset;

	lsu_pkg::tag_t       i_tag;
	logic [4:0]          i_inst_rd;
	lsu_pkg::data_t      i_rd;
	lsu_pkg::data_t      i_pc_next;
	logic                i_mem_read;
	logic                i_mem_write;
	lsu_pkg::mem_width_t i_mem_width;
	logic                i_mem_signed;
	lsu_pkg::data_t      i_mem_address;
	lsu_pkg::tag_t       o_tag;
	logic [4:0]          o_inst_rd;
	lsu_pkg::data_t      o_rd;
	lsu_pkg::data_t      o_pc_next;
	logic                o_stall;

	// Reference memory and expected retirement values
	lsu_pkg::data_t ref_mem [MEM_WORDS];
	lsu_pkg::tag_t  exp_tag = '0;
	logic [4:0]     exp_inst_rd;
	lsu_pkg::data_t exp_rd;
	lsu_pkg::data_t exp_pc_next;
	logic           mem_pending = 1'b0;
	int             issued_count = 0;
	int             retired_count = 0;
	lsu_pkg::tag_t  seen_tag = '0;
	logic [31:0]    lfsr = 32'h11dc_0e6d;

	tb_clock tb_clock_inst (
		.o_clock (clock),
		.o_reset (reset)
	);

	lsu_top #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_WORDS (BANK_WORDS)
	) lsu_top_inst (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_tag         (i_tag),
		.i_inst_rd     (i_inst_rd),
		.i_rd          (i_rd),
		.i_pc_next     (i_pc_next),
		.i_mem_read    (i_mem_read),
		.i_mem_write   (i_mem_write),
		.i_mem_width   (i_mem_width),
		.i_mem_signed  (i_mem_signed),
		.i_mem_address (i_mem_address),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_pc_next     (o_pc_next),
		.o_stall       (o_stall)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic lsu_pkg::data_t take_bits(input int count);
		lsu_pkg::data_t bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic lsu_pkg::data_t fill_word(input lsu_pkg::data_t address);
		return address ^ {address[15:0], address[31:16]} ^ 32'ha5c3_0f96;
	endfunction

	// Addresses past the banks wrap
	function automatic int word_index(input lsu_pkg::data_t address);
		lsu_pkg::data_t word_address;
		word_address = address >> 2;
		return int'(word_address % MEM_WORDS);
	endfunction

	function automatic lsu_pkg::data_t load_result(input lsu_pkg::data_t word,
			input lsu_pkg::mem_width_t width, input logic sign, input logic [1:0] offset);
		int          base;
		logic [7:0]  b;
		logic [15:0] h;
		base = 8 * int'(offset);
		b    = word[base +: 8];
		h    = word[base +: 16];
		case (width)
			lsu_pkg::WIDTH_BYTE: return sign ? {{24{b[7]}}, b} : {24'd0, b};
			lsu_pkg::WIDTH_HALF: return sign ? {{16{h[15]}}, h} : {16'd0, h};
			default:             return word;
		endcase
	endfunction

	function automatic lsu_pkg::data_t store_merge(input lsu_pkg::data_t word,
			input lsu_pkg::data_t value, input lsu_pkg::mem_width_t width,
			input logic [1:0] offset);
		int             base;
		lsu_pkg::data_t merged;
		base   = 8 * int'(offset);
		merged = word;
		case (width)
			lsu_pkg::WIDTH_BYTE: merged[base +: 8] = value[7:0];
			lsu_pkg::WIDTH_HALF: merged[base +: 16] = value[15:0];
			default:             merged = value;
		endcase
		return merged;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input lsu_pkg::data_t actual,
			input lsu_pkg::data_t expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_tag(input string name, input lsu_pkg::tag_t actual,
			input lsu_pkg::tag_t expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_rd_index(input string name, input logic [4:0] actual,
			input logic [4:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Updates the model, drives one instruction and waits for it to retire
	task automatic issue(input logic read, input logic write, input lsu_pkg::mem_width_t width,
			input logic sign, input lsu_pkg::data_t address, input lsu_pkg::data_t value);
		int             index;
		lsu_pkg::data_t r;
		index       = word_index(address);
		exp_tag     = exp_tag + lsu_pkg::tag_t'(1);
		r           = take_bits(5);
		exp_inst_rd = r[4:0];
		exp_pc_next = take_bits(32);
		if (read) begin
			exp_rd = load_result(ref_mem[index], width, sign, address[1:0]);
		end else if (write) begin
			ref_mem[index] = store_merge(ref_mem[index], value, width, address[1:0]);
		end else begin
			exp_rd = value;
		end
		mem_pending = read || write;
		@(posedge clock);
		i_tag         <= exp_tag;
		i_inst_rd     <= exp_inst_rd;
		i_rd          <= value;
		i_pc_next     <= exp_pc_next;
		i_mem_read    <= read;
		i_mem_write   <= write;
		i_mem_width   <= width;
		i_mem_signed  <= sign;
		i_mem_address <= address;
		issued_count = issued_count + 1;
		wait (retired_count == issued_count);
	endtask

	// Compares at the falling edge, where outputs are stable
	always @(negedge clock) begin
		if (!reset) begin
			if (o_tag !== seen_tag) begin
				if (retired_count == issued_count) begin
					$display("o_tag changed at %0t with no instruction pending", $time);
					stop_with_failure();
				end else begin
					check_tag("o_tag", o_tag, exp_tag);
					check_rd_index("o_inst_rd", o_inst_rd, exp_inst_rd);
					check_data("o_rd", o_rd, exp_rd);
					check_data("o_pc_next", o_pc_next, exp_pc_next);
					seen_tag      = o_tag;
					retired_count = retired_count + 1;
				end
			end
			check_flag("o_stall", o_stall, (issued_count != retired_count) && mem_pending);
		end
	end

	initial begin
		repeat (INSTRUCTION_COUNT * 40 + 16) @(posedge clock);
		$display("Timeout: an instruction never retired");
		stop_with_failure();
	end

	initial begin
		lsu_pkg::data_t      patterns [2];
		lsu_pkg::data_t      address;
		lsu_pkg::data_t      value;
		lsu_pkg::data_t      r;
		lsu_pkg::mem_width_t width;
		logic [1:0]          kind;
		i_tag         = '0;
		i_inst_rd     = '0;
		i_rd          = '0;
		i_pc_next     = '0;
		i_mem_read    = 1'b0;
		i_mem_write   = 1'b0;
		i_mem_width   = lsu_pkg::WIDTH_WORD;
		i_mem_signed  = 1'b0;
		i_mem_address = '0;
		patterns[0]   = 32'h7f80_01fe;
		patterns[1]   = 32'h8001_ff7e;
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(negedge clock);
		check_flag("o_stall", o_stall, 1'b0);

		// Non-memory pass-through
		for (int n = 0; n < 2; n++) begin
			value = take_bits(32);
			issue(1'b0, 1'b0, lsu_pkg::WIDTH_WORD, 1'b0, '0, value);
		end

		// Fill every word so later loads are defined
		for (int k = 0; k < MEM_WORDS; k++) begin
			address = k * 4;
			issue(1'b0, 1'b1, lsu_pkg::WIDTH_WORD, 1'b0, address, fill_word(address));
		end

		// Word store then load, stepping through all banks and past the top
		for (int k = 0; k < 16; k++) begin
			address = k * 32'h114;
			value   = take_bits(32);
			issue(1'b0, 1'b1, lsu_pkg::WIDTH_WORD, 1'b0, address, value);
			issue(1'b1, 1'b0, lsu_pkg::WIDTH_WORD, 1'b0, address, '0);
		end

		// Sub-word loads at each legal offset
		for (int p = 0; p < 2; p++) begin
			address = 32'h0000_0238 + p * 4;
			issue(1'b0, 1'b1, lsu_pkg::WIDTH_WORD, 1'b0, address, patterns[p]);
			for (int offset = 0; offset < 4; offset++) begin
				for (int s = 0; s < 2; s++) begin
					issue(1'b1, 1'b0, lsu_pkg::WIDTH_BYTE, s[0], address + offset, '0);
				end
			end
			for (int offset = 0; offset < 4; offset += 2) begin
				for (int s = 0; s < 2; s++) begin
					issue(1'b1, 1'b0, lsu_pkg::WIDTH_HALF, s[0], address + offset, '0);
				end
			end
		end

		// Sub-word stores, each checked by a word load
		address = 32'h0000_0350;
		for (int offset = 0; offset < 4; offset++) begin
			value = take_bits(32);
			issue(1'b0, 1'b1, lsu_pkg::WIDTH_BYTE, 1'b0, address + offset, value);
			issue(1'b1, 1'b0, lsu_pkg::WIDTH_WORD, 1'b0, address, '0);
		end
		for (int offset = 0; offset < 4; offset += 2) begin
			value = take_bits(32);
			issue(1'b0, 1'b1, lsu_pkg::WIDTH_HALF, 1'b0, address + offset, value);
			issue(1'b1, 1'b0, lsu_pkg::WIDTH_WORD, 1'b0, address, '0);
		end

		// Random mix over a 4 KB range, so addresses wrap
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			r    = take_bits(2);
			kind = r[1:0];
			r    = take_bits(2);
			case (r[1:0])
				2'd0:    width = lsu_pkg::WIDTH_BYTE;
				2'd1:    width = lsu_pkg::WIDTH_HALF;
				default: width = lsu_pkg::WIDTH_WORD;
			endcase
			r       = take_bits(12);
			address = {20'd0, r[11:0]};
			if (width == lsu_pkg::WIDTH_HALF) begin
				address[0] = 1'b0;
			end else if (width == lsu_pkg::WIDTH_WORD) begin
				address[1:0] = 2'b00;
			end
			r     = take_bits(1);
			value = take_bits(32);
			issue(kind == 2'd1 || kind == 2'd3, kind == 2'd2, width, r[0], address, value);
		end

		@(negedge clock);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* list.f */
design/lsu_pkg.sv
design/mem_stage.sv
design/bank_router.sv
design/sram_bank.sv
design/bank_return.sv
design/lsu_top.sv
dv/tb_clock.sv
dv/tb_lsu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu -f list.f -o tb_lsu
	./obj_dir/tb_lsu

clean:
	rm -rf obj_dir
